// File: compile.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/backend_pkg.sv
rtl/int_decode.sv
rtl/int_issue_queue.sv
rtl/int_execute.sv
rtl/int_result.sv
rtl/int_backend.sv
dv/tb_clock.sv
dv/int_backend_tb.sv

// File: dv/int_backend_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module int_backend_tb;
    localparam int NUM_INSTR = 400;
    // ten cycles per instruction covers stalls, idle cycles and the drain
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 10;
    localparam int DRAIN_CYCLES = 20;

    // one writeback still owed by the DUT
    typedef struct packed {
        logic [`REG_IDX_W-1:0] rd;
        logic [`XLEN-1:0]      data;
    } expect_t;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid;
    logic [31:0]           instr;
    logic                  instr_ready;
    logic                  illegal_instr;
    logic                  wb_valid;
    backend_pkg::reg_idx_t wb_rd;
    backend_pkg::data_t    wb_data;
    backend_pkg::arf_t     arf_out;

    logic [31:0]      rng_state = 32'h69a5f56d;
    // in-order reference register file
    logic [`XLEN-1:0] model_rf [`NUM_ARCH_REGS];
    // oldest first, searched by rd
    expect_t          exp_q [$];
    logic             illegal_expected;
    int               cycle_count = 0;
    int               sent;
    int               accepted;
    // valid/ready transfers seen on the rising edge
    int               handshakes = 0;

    tb_clock tb_clock_inst (
        .clk (clk),
        .rst (rst)
    );

    int_backend int_backend_inst (
        .clk           (clk),
        .rst           (rst),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_ready   (instr_ready),
        .illegal_instr (illegal_instr),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .arf_out       (arf_out)
    );

    // lcg step
    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // upper bits only, low lcg bits cycle fast
    function automatic int unsigned pick(input int unsigned n);
        logic [31:0] r;
        r = next_random();
        return r[31:8] % n;
    endfunction

    // registers x0..x7 only, so chains form often
    function automatic logic [31:0] gen_instr();
        logic [31:0]  r;
        logic [6:0]   opc;
        logic [6:0]   f7;
        logic [2:0]   f3;
        logic [4:0]   rd;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        int unsigned  kind;
        r = next_random();
        rd = 5'(pick(8));
        rs1 = 5'(pick(8));
        rs2 = 5'(pick(8));
        f3 = 3'(pick(8));
        f7 = 7'b0;
        kind = pick(100);
        if (kind < 5) begin
            // any major opcode outside OP, OP-IMM and LUI
            opc = 7'(pick(128));
            while (opc == isa_pkg::OPC_OP || opc == isa_pkg::OPC_OP_IMM
                   || opc == isa_pkg::OPC_LUI) begin
                opc = 7'(pick(128));
            end
            return {r[31:7], opc};
        end else if (kind < 50) begin
            // sub and sra are the only alternate funct7 encodings
            if ((f3 == 3'b000 || f3 == 3'b101) && r[0]) begin
                f7 = 7'b0100000;
            end
            return {f7, rs2, rs1, f3, rd, 7'(isa_pkg::OPC_OP)};
        end else if (kind < 90) begin
            // shift immediates carry a 5-bit shamt
            if (f3 == 3'b001) begin
                return {7'b0, r[24:20], rs1, f3, rd, 7'(isa_pkg::OPC_OP_IMM)};
            end
            if (f3 == 3'b101) begin
                f7 = r[1] ? 7'b0100000 : 7'b0;
                return {f7, r[24:20], rs1, f3, rd, 7'(isa_pkg::OPC_OP_IMM)};
            end
            return {r[31:20], rs1, f3, rd, 7'(isa_pkg::OPC_OP_IMM)};
        end
        return {r[31:12], rd, 7'(isa_pkg::OPC_LUI)};
    endfunction

    // rv32i result of a legal word against the model state
    function automatic logic [`XLEN-1:0] ref_result(input logic [31:0] w);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] res;
        logic [4:0]       shamt;
        logic             alt;
        a = model_rf[w[19:15]];
        if (w[6:0] == isa_pkg::OPC_OP_IMM) begin
            b = {{20{w[31]}}, w[31:20]};
            // bit 30 of an immediate only matters for srai
            alt = (w[14:12] == 3'b101) && w[30];
        end else begin
            b = model_rf[w[24:20]];
            alt = w[30];
        end
        shamt = b[4:0];
        case (w[14:12])
            3'b000:  res = alt ? a - b : a + b;
            3'b001:  res = a << shamt;
            3'b010:  res = ($signed(a) < $signed(b)) ? 1 : 0;
            3'b011:  res = (a < b) ? 1 : 0;
            3'b100:  res = a ^ b;
            3'b101: begin
                // arithmetic shift keeps the sign bit
                if (alt) begin
                    res = $signed(a) >>> shamt;
                end else begin
                    res = a >> shamt;
                end
            end
            3'b110:  res = a | b;
            default: res = a & b;
        endcase
        if (w[6:0] == isa_pkg::OPC_LUI) begin
            res = {w[31:12], 12'b0};
        end
        return res;
    endfunction

    task automatic fail_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first failing check");
    endtask

    // program order step of the model, one accepted word
    task automatic apply_accept(input logic [31:0] w);
        logic             legal;
        logic [`XLEN-1:0] value;
        legal = (w[6:0] == isa_pkg::OPC_OP) || (w[6:0] == isa_pkg::OPC_OP_IMM)
                || (w[6:0] == isa_pkg::OPC_LUI);
        illegal_expected = !legal;
        // x0 targets write nothing
        if (legal && (w[11:7] != 5'd0)) begin
            value = ref_result(w);
            model_rf[w[11:7]] = value;
            exp_q.push_back(expect_t'{rd: w[11:7], data: value});
        end
    endtask

    task automatic check_reset_state();
        assert (instr_ready == 1'b0) else begin
            $display("ERR instr_ready got %0h expected 0", instr_ready);
            fail_run();
        end
        assert (wb_valid == 1'b0) else begin
            $display("ERR wb_valid got %0h expected 0", wb_valid);
            fail_run();
        end
        assert (illegal_instr == 1'b0) else begin
            $display("ERR illegal_instr got %0h expected 0", illegal_instr);
            fail_run();
        end
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            assert (arf_out[i] == '0) else begin
                $display("ERR arf_out[%0d] got %08h expected 00000000", i, arf_out[i]);
                fail_run();
            end
        end
    endtask

    // outputs settled since the last rising edge
    task automatic check_outputs();
        int idx;
        assert (illegal_instr == illegal_expected) else begin
            $display("ERR illegal_instr got %0h expected %0h",
                     illegal_instr, illegal_expected);
            fail_run();
        end
        if (wb_valid) begin
            assert (wb_rd != '0) else begin
                $display("ERR wb_rd got %02h expected nonzero", wb_rd);
                fail_run();
            end
            // oldest pending write to this register
            idx = -1;
            for (int i = 0; i < exp_q.size(); i++) begin
                if (idx < 0 && exp_q[i].rd == wb_rd) begin
                    idx = i;
                end
            end
            assert (idx >= 0) else begin
                $display("writeback to x%0d with no instruction outstanding for it", wb_rd);
                fail_run();
            end
            assert (wb_data == exp_q[idx].data) else begin
                $display("ERR wb_data x%0d got %08h expected %08h",
                         wb_rd, wb_data, exp_q[idx].data);
                fail_run();
            end
            exp_q.delete(idx);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    // count transfers at the edge itself, independent of the driver
    always @(posedge clk) begin
        if (!rst && instr_valid && instr_ready) begin
            handshakes <= handshakes + 1;
        end
    end

    initial begin
        logic [31:0] cur;
        logic        pending;
        instr_valid = 1'b0;
        instr = '0;
        illegal_expected = 1'b0;
        sent = 0;
        accepted = 0;
        pending = 1'b0;
        cur = '0;
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            model_rf[i] = '0;
        end

        // whole reset plus the first cycle after it
        do begin
            @(negedge clk);
            check_reset_state();
        end while (rst);

        while (accepted < NUM_INSTR) begin
            @(negedge clk);
            check_outputs();
            // new word, or an idle cycle now and then
            if (!pending && sent < NUM_INSTR && pick(100) >= 15) begin
                cur = gen_instr();
                pending = 1'b1;
                sent++;
            end
            instr_valid = pending;
            // junk on the bus while idle
            instr = pending ? cur : next_random();
            // ready settles well before the next rising edge
            #1;
            illegal_expected = 1'b0;
            if (instr_valid && instr_ready) begin
                accepted++;
                apply_accept(cur);
                pending = 1'b0;
            end
        end

        repeat (DRAIN_CYCLES) begin
            @(negedge clk);
            check_outputs();
            instr_valid = 1'b0;
            instr = '0;
            illegal_expected = 1'b0;
        end

        assert (handshakes == sent) else begin
            $display("%0d instructions driven but %0d transfers seen on the port",
                     sent, handshakes);
            fail_run();
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d writebacks never arrived after the drain", exp_q.size());
            fail_run();
        end
        for (int i = 0; i < `NUM_ARCH_REGS; i++) begin
            assert (arf_out[i] == model_rf[i]) else begin
                $display("ERR arf_out[%0d] got %08h expected %08h", i, arf_out[i], model_rf[i]);
                fail_run();
            end
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/tb_clock.sv
`timescale 1ns/100ps
`default_nettype none

// free-running testbench clock plus synchronous reset
module tb_clock #(
    // 4 ns period
    parameter int HALF_PERIOD_NS = 2,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clk = ~clk;
        end
    end

    // high over the first rising edges, dropped after the last one
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: rtl/backend_pkg.sv
`default_nettype none

`include "core_consts.svh"

package backend_pkg;

    typedef logic [`XLEN-1:0] data_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // whole register file as one vector, x0 at index 0
    typedef logic [`NUM_ARCH_REGS-1:0][`XLEN-1:0] arf_t;

    // source operand slot
    // tag is the producing register index while not ready
    typedef struct packed {
        logic     ready;
        reg_idx_t tag;
        data_t    value;
    } operand_t;

    // one issue queue slot, written by decode
    typedef struct packed {
        isa_pkg::alu_op_t alu_op;
        operand_t         src1;
        operand_t         src2;
        logic             dst_valid;
        reg_idx_t         rd;
    } iq_entry_t;

    // issue queue to alu
    typedef struct packed {
        isa_pkg::alu_op_t alu_op;
        data_t            a;
        data_t            b;
        logic             dst_valid;
        reg_idx_t         rd;
    } issue_t;

    // alu result, also the wakeup broadcast
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        data_t    data;
    } result_t;

endpackage

`default_nettype wire

// File: rtl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// integer datapath width
`define XLEN 32

// architectural integer registers, x0 included
`define NUM_ARCH_REGS 32

// register index width, also the wakeup tag width
`define REG_IDX_W 5

// integer issue queue entries
// 2 and 8 work as well
`define IQ_DEPTH 4

`endif

// File: rtl/int_backend.sv
`timescale 1ns/100ps
`default_nettype none

module int_backend (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    output logic                  instr_ready,
    output logic                  illegal_instr,
    output logic                  wb_valid,
    output backend_pkg::reg_idx_t wb_rd,
    output backend_pkg::data_t    wb_data,
    output backend_pkg::arf_t     arf_out
);
    // decode <-> issue queue
    logic                   dispatch_valid;
    backend_pkg::iq_entry_t dispatch_entry;
    logic                   iq_full;
    // issue queue -> alu
    logic                   issue_valid;
    backend_pkg::issue_t    issue;
    // alu -> result, result -> wakeup
    backend_pkg::result_t   exec_result;
    backend_pkg::result_t   bcast;

    int_decode int_decode_inst (
        .clk            (clk),
        .rst            (rst),
        .instr_valid    (instr_valid),
        .instr          (isa_pkg::instr_t'(instr)),
        .iq_full        (iq_full),
        .bcast          (bcast),
        // source reads see the write-through register file
        .arf            (arf_out),
        .instr_ready    (instr_ready),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .illegal_instr  (illegal_instr)
    );

    int_issue_queue int_issue_queue_inst (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_entry (dispatch_entry),
        .bcast          (bcast),
        .iq_full        (iq_full),
        .issue_valid    (issue_valid),
        .issue          (issue)
    );

    // single cycle alu, never back-pressures the queue
    int_execute int_execute_inst (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .exec_result (exec_result)
    );

    int_result int_result_inst (
        .clk         (clk),
        .rst         (rst),
        .exec_result (exec_result),
        .bcast       (bcast),
        .arf         (arf_out),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

endmodule

`default_nettype wire

// File: rtl/int_decode.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module int_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instr_valid,
    input  isa_pkg::instr_t        instr,
    input  logic                   iq_full,
    input  backend_pkg::result_t   bcast,
    input  backend_pkg::arf_t      arf,
    output logic                   instr_ready,
    output logic                   dispatch_valid,
    output backend_pkg::iq_entry_t dispatch_entry,
    output logic                   illegal_instr
);
    // scoreboard, one busy bit per architectural register
    logic [`NUM_ARCH_REGS-1:0] busy;
    // low for the first cycle out of reset
    logic                      running;
    logic                      legal;
    logic                      is_lui;
    logic                      use_imm;
    logic                      alt;
    isa_pkg::alu_op_t          alu_op;
    logic [`XLEN-1:0]          imm;
    logic                      dst_valid;
    logic                      dst_busy;
    logic                      accept;

    // x0, then register file, then same-cycle broadcast, else wait on tag
    function automatic backend_pkg::operand_t read_src(
        input logic [`REG_IDX_W-1:0]     idx,
        input logic [`NUM_ARCH_REGS-1:0] busy_v,
        input backend_pkg::arf_t         rf,
        input backend_pkg::result_t      bc
    );
        backend_pkg::operand_t op;
        op.tag = idx;
        op.ready = 1'b1;
        op.value = '0;
        if (idx == '0) begin
            op.value = '0;
        end else if (!busy_v[idx]) begin
            op.value = rf[idx];
        end else if (bc.valid && (bc.rd == idx)) begin
            op.value = bc.data;
        end else begin
            op.ready = 1'b0;
        end
        return op;
    endfunction

    always_comb begin
        is_lui = (instr.opcode == isa_pkg::OPC_LUI);
        use_imm = (instr.opcode == isa_pkg::OPC_OP_IMM);
        legal = is_lui || use_imm || (instr.opcode == isa_pkg::OPC_OP);
        // funct7[5] picks sub/sra, imm only sees it on shifts
        alt = instr.funct7[5];
        alu_op = isa_pkg::ALU_ADD;
        case (instr.funct3)
            isa_pkg::F3_ADD:  alu_op = (alt && !use_imm) ? isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
            isa_pkg::F3_SLL:  alu_op = isa_pkg::ALU_SLL;
            isa_pkg::F3_SLT:  alu_op = isa_pkg::ALU_SLT;
            isa_pkg::F3_SLTU: alu_op = isa_pkg::ALU_SLTU;
            isa_pkg::F3_XOR:  alu_op = isa_pkg::ALU_XOR;
            isa_pkg::F3_SR:   alu_op = alt ? isa_pkg::ALU_SRA : isa_pkg::ALU_SRL;
            isa_pkg::F3_OR:   alu_op = isa_pkg::ALU_OR;
            isa_pkg::F3_AND:  alu_op = isa_pkg::ALU_AND;
        endcase
        if (is_lui) begin
            alu_op = isa_pkg::ALU_PASS_B;
            // upper 20 bits, low 12 zero
            imm = {instr.funct7, instr.rs2, instr.rs1, instr.funct3, 12'b0};
        end else begin
            // i-type, sign extended from bit 31
            imm = {{(`XLEN-12){instr.funct7[6]}}, instr.funct7, instr.rs2};
        end
    end

    always_comb begin
        // writes to x0 are dropped here
        dst_valid = legal && (instr.rd != '0);
        dst_busy = dst_valid && busy[instr.rd];
        instr_ready = running && !iq_full && !dst_busy;
        accept = instr_valid && instr_ready;
        dispatch_valid = accept && legal;

        dispatch_entry.alu_op = alu_op;
        // lui has no rs1, read x0 so it never waits
        dispatch_entry.src1 = read_src(is_lui ? '0 : instr.rs1, busy, arf, bcast);
        if (use_imm || is_lui) begin
            dispatch_entry.src2 = '{ready: 1'b1, tag: '0, value: imm};
        end else begin
            dispatch_entry.src2 = read_src(instr.rs2, busy, arf, bcast);
        end
        dispatch_entry.dst_valid = dst_valid;
        dispatch_entry.rd = instr.rd;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            illegal_instr <= 1'b0;
            busy <= '0;
        end else begin
            running <= 1'b1;
            // one-cycle flag, word itself is dropped
            illegal_instr <= accept && !legal;
            // never the same register, dispatch stalls on busy rd
            if (bcast.valid) begin
                busy[bcast.rd] <= 1'b0;
            end
            if (dispatch_valid && dst_valid) begin
                busy[instr.rd] <= 1'b1;
            end
        end
    end

    // a register still being written back counts as busy
    a_no_busy_dst: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid && dispatch_entry.dst_valid
        |-> !(bcast.valid && (bcast.rd == dispatch_entry.rd)));

    // every writeback belongs to an instruction that marked its rd busy
    a_bcast_was_busy: assert property (@(posedge clk) disable iff (rst)
        bcast.valid |-> busy[bcast.rd]);

endmodule

`default_nettype wire

// File: rtl/int_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module int_execute (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  backend_pkg::issue_t  issue,
    output backend_pkg::result_t exec_result
);
    localparam int SHAMT_W = $clog2(`XLEN);

    logic [SHAMT_W-1:0] shamt;
    backend_pkg::data_t alu_out;

    // shifts only use the low bits of b
    assign shamt = issue.b[SHAMT_W-1:0];

    always_comb begin
        case (issue.alu_op)
            isa_pkg::ALU_ADD:    alu_out = issue.a + issue.b;
            isa_pkg::ALU_SUB:    alu_out = issue.a - issue.b;
            isa_pkg::ALU_SLL:    alu_out = issue.a << shamt;
            // signed compare
            isa_pkg::ALU_SLT:    alu_out = backend_pkg::data_t'($signed(issue.a) < $signed(issue.b));
            isa_pkg::ALU_SLTU:   alu_out = backend_pkg::data_t'(issue.a < issue.b);
            isa_pkg::ALU_XOR:    alu_out = issue.a ^ issue.b;
            isa_pkg::ALU_SRL:    alu_out = issue.a >> shamt;
            isa_pkg::ALU_SRA:    alu_out = backend_pkg::data_t'($signed(issue.a) >>> shamt);
            isa_pkg::ALU_OR:     alu_out = issue.a | issue.b;
            isa_pkg::ALU_AND:    alu_out = issue.a & issue.b;
            // lui
            isa_pkg::ALU_PASS_B: alu_out = issue.b;
            default:             alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_result.valid <= 1'b0;
        end else begin
            // rd of x0 executes but writes nothing
            exec_result.valid <= issue_valid && issue.dst_valid;
        end
        exec_result.rd <= issue.rd;
        exec_result.data <= alu_out;
    end

endmodule

`default_nettype wire

// File: rtl/int_issue_queue.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_consts.svh"

module int_issue_queue (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   dispatch_valid,
    input  backend_pkg::iq_entry_t dispatch_entry,
    input  backend_pkg::result_t   bcast,
    output logic                   iq_full,
    output logic                   issue_valid,
    output backend_pkg::issue_t    issue
);
    localparam int IDX_W = $clog2(`IQ_DEPTH);

    // slot 0 is always the oldest, queue kept compacted
    backend_pkg::iq_entry_t entries      [`IQ_DEPTH];
    backend_pkg::iq_entry_t woken        [`IQ_DEPTH];
    backend_pkg::iq_entry_t entries_next [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0]   valid;
    logic [`IQ_DEPTH-1:0]   valid_next;
    logic                   sel_found;
    logic [IDX_W-1:0]       sel_idx;

    // grab broadcast data on tag match
    function automatic backend_pkg::operand_t wake(
        input backend_pkg::operand_t op,
        input backend_pkg::result_t  bc
    );
        backend_pkg::operand_t res;
        res = op;
        if (!op.ready && bc.valid && (bc.rd == op.tag)) begin
            res.ready = 1'b1;
            res.value = bc.data;
        end
        return res;
    endfunction

    assign iq_full = &valid;

    // wakeup, then pick oldest with both operands ready
    // selecting on the woken view saves a cycle on dependent chains
    always_comb begin
        sel_found = 1'b0;
        sel_idx = '0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            woken[i] = entries[i];
            woken[i].src1 = wake(entries[i].src1, bcast);
            woken[i].src2 = wake(entries[i].src2, bcast);
            if (!sel_found && valid[i] && woken[i].src1.ready && woken[i].src2.ready) begin
                sel_found = 1'b1;
                sel_idx = IDX_W'(i);
            end
        end
        // selected entry goes to the alu in this same cycle
        issue_valid = sel_found;
        issue = '{
            alu_op:    woken[sel_idx].alu_op,
            a:         woken[sel_idx].src1.value,
            b:         woken[sel_idx].src2.value,
            dst_valid: woken[sel_idx].dst_valid,
            rd:        woken[sel_idx].rd
        };
    end

    // compaction
    // slots at and above the issued one move down by one
    always_comb begin : compact
        int   src;
        logic placed;
        placed = 1'b0;
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            src = i;
            if (sel_found && (i >= int'(sel_idx))) begin
                src = i + 1;
            end
            if (src < `IQ_DEPTH) begin
                entries_next[i] = woken[src];
                valid_next[i] = valid[src];
            end else begin
                // top slot frees up
                entries_next[i] = woken[i];
                valid_next[i] = 1'b0;
            end
        end
        // new entry lands in the first free slot, youngest position
        for (int i = 0; i < `IQ_DEPTH; i++) begin
            if (dispatch_valid && !placed && !valid_next[i]) begin
                entries_next[i] = dispatch_entry;
                valid_next[i] = 1'b1;
                placed = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else begin
            valid <= valid_next;
        end
        entries <= entries_next;
    end

    // decode has to honor iq_full
    a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> !iq_full);

endmodule

`default_nettype wire

// File: rtl/int_result.sv
`timescale 1ns/100ps
`default_nettype none

module int_result (
    input  logic                  clk,
    input  logic                  rst,
    input  backend_pkg::result_t  exec_result,
    output backend_pkg::result_t  bcast,
    output backend_pkg::arf_t     arf,
    output logic                  wb_valid,
    output backend_pkg::reg_idx_t wb_rd,
    output backend_pkg::data_t    wb_data
);
    // architectural register file, all zero out of reset
    backend_pkg::arf_t regs;

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '0;
        end else if (exec_result.valid) begin
            regs[exec_result.rd] <= exec_result.data;
        end
    end

    // write-through view
    // new value shows up in the same cycle as the broadcast
    always_comb begin
        arf = regs;
        if (exec_result.valid) begin
            arf[exec_result.rd] = exec_result.data;
        end
    end

    // wakeup for decode and the issue queue
    assign bcast = exec_result;

    // writeback port
    assign wb_valid = exec_result.valid;
    assign wb_rd = exec_result.rd;
    assign wb_data = exec_result.data;

    // decode drops rd of x0 upstream
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst)
        exec_result.valid |-> (exec_result.rd != '0));

endmodule

`default_nettype wire

// File: rtl/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // major opcodes handled by the integer back end
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_t;

    // funct3 of OP / OP-IMM
    // funct7 bit 5 splits add/sub and srl/sra
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_t;

    // alu operations, pass_b carries the lui immediate
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // r-type field layout
    // opcode kept raw so unknown encodings can be flagged
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

endpackage

`default_nettype wire
